//--- Bender.yml
package:
  name: dccm_ctl

sources:
  # packages first, then the pipe stages and the top level
  - source/dccm_geom_pkg.sv
  - source/lsu_pipe_pkg.sv
  - source/ld_issue.sv
  - source/stbuf_commit_arb.sv
  - source/ld_return.sv
  - source/dccm_ctl_top.sv

  - target: test
    files:
      - tb/dccm_ctl_scoreboard.sv
      - tb/dccm_ctl_chk.sv
      - tb/tb_dccm_ctl.sv

//--- dccm_ctl.f
source/dccm_geom_pkg.sv
source/lsu_pipe_pkg.sv
source/ld_issue.sv
source/stbuf_commit_arb.sv
source/ld_return.sv
source/dccm_ctl_top.sv
tb/dccm_ctl_scoreboard.sv
tb/dccm_ctl_chk.sv
tb/tb_dccm_ctl.sv

//--- source/dccm_ctl_top.sv
// DCCM controller top
// Load path of the d, m and r stages plus the store buffer commit onto
// the DCCM write port. The DCCM array itself sits outside.
`timescale 1ns/100ps
`default_nettype none

module dccm_ctl_top #(
   parameter int unsigned BANK_BITS = dccm_geom_pkg::DEFAULT_BANK_BITS
) (
   input  logic                     clk,
   input  logic                     arst_n,

   // load and store buffer side
   input  lsu_pipe_pkg::ld_req_t    ld_req,
   input  lsu_pipe_pkg::stbuf_req_t stbuf_req,
   input  lsu_pipe_pkg::fwd_t       fwd,                    // sampled in m
   output logic                     stbuf_commit,
   output lsu_pipe_pkg::ld_rsp_t    ld_rsp,

   // DCCM array side
   output lsu_pipe_pkg::dccm_rd_t   dccm_rd,
   output lsu_pipe_pkg::dccm_wr_t   dccm_wr,
   input  dccm_geom_pkg::word_t     dccm_rd_data_lo,        // one cycle after rden
   input  dccm_geom_pkg::word_t     dccm_rd_data_hi
);

   lsu_pipe_pkg::ld_pkt_t ld_pkt_m;                         // d to m load packet

   // d stage
   ld_issue i_ld_issue (
      .clk      (clk),
      .arst_n   (arst_n),
      .ld_req   (ld_req),
      .dccm_rd  (dccm_rd),
      .ld_pkt_m (ld_pkt_m)
   );

   // write port arbitration against the d stage read
   stbuf_commit_arb #(
      .BANK_BITS (BANK_BITS)
   ) i_stbuf_commit_arb (
      .dccm_rd      (dccm_rd),
      .stbuf_req    (stbuf_req),
      .stbuf_commit (stbuf_commit),
      .dccm_wr      (dccm_wr)
   );

   // m and r stages
   ld_return i_ld_return (
      .clk             (clk),
      .arst_n          (arst_n),
      .ld_pkt_m        (ld_pkt_m),
      .fwd             (fwd),
      .dccm_rd_data_lo (dccm_rd_data_lo),
      .dccm_rd_data_hi (dccm_rd_data_hi),
      .ld_rsp          (ld_rsp)
   );

endmodule : dccm_ctl_top

`default_nettype wire

//--- source/dccm_geom_pkg.sv
// DCCM geometry
// widths, address bits and bank selection defaults shared by the
// load/store pipe and the memory port
`default_nettype none

package dccm_geom_pkg;

   // byte address space of the DCCM
   localparam int unsigned DCCM_BITS = 16;

   // one bank word and its byte lanes
   localparam int unsigned DATA_WIDTH = 32;
   localparam int unsigned BYTE_WIDTH = 4;
   localparam int unsigned WIDTH_BITS = 2;                  // byte offset within a word

   // bank select bits sit just above the byte offset
   localparam int unsigned DEFAULT_BANK_BITS = 2;

   typedef logic [DCCM_BITS-1:0]  addr_t;                   // DCCM byte address
   typedef logic [DATA_WIDTH-1:0] word_t;                   // one bank word

endpackage : dccm_geom_pkg

`default_nettype wire

//--- source/ld_issue.sv
// Load issue, d stage
// Decodes the load size, finds the end address and whether the load
// spans two words, drives the DCCM read port in the issue cycle and
// carries the load packet into m.
`timescale 1ns/100ps
`default_nettype none

module ld_issue (
   input  logic                   clk,
   input  logic                   arst_n,
   input  lsu_pipe_pkg::ld_req_t  ld_req,
   output lsu_pipe_pkg::dccm_rd_t dccm_rd,
   output lsu_pipe_pkg::ld_pkt_t  ld_pkt_m
);

   localparam int unsigned AB = dccm_geom_pkg::DCCM_BITS;
   localparam int unsigned WB = dccm_geom_pkg::WIDTH_BITS;

   logic [WB-1:0]          last_byte;                       // size in bytes minus one
   dccm_geom_pkg::addr_t   end_addr;
   logic                   dual_d;

   // m stage registers
   logic                   valid_m;
   lsu_pipe_pkg::ld_size_e size_m;
   logic [WB-1:0]          offset_m;
   logic                   dual_m;

   always_comb begin
      case (ld_req.size)
         lsu_pipe_pkg::LD_BYTE: last_byte = WB'(0);
         lsu_pipe_pkg::LD_HALF: last_byte = WB'(1);
         default:               last_byte = WB'(3);         // word and the unused code
      endcase
   end

   assign end_addr = ld_req.addr + dccm_geom_pkg::addr_t'(last_byte);

   // the last byte falls into the next word
   assign dual_d = end_addr[AB-1:WB] != ld_req.addr[AB-1:WB];

   // read port is driven straight from the issue strobe
   assign dccm_rd.rden    = ld_req.valid;
   assign dccm_rd.addr_lo = {ld_req.addr[AB-1:WB], {WB{1'b0}}};
   assign dccm_rd.addr_hi = {end_addr[AB-1:WB], {WB{1'b0}}};  // same word unless dual

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_m <= 1'b0;
      end else begin
         valid_m <= ld_req.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (ld_req.valid) begin
         size_m   <= ld_req.size;
         offset_m <= ld_req.addr[WB-1:0];
         dual_m   <= dual_d;
      end
   end

   assign ld_pkt_m = '{
      valid:  valid_m,
      size:   size_m,
      offset: offset_m,
      dual:   dual_m
   };

endmodule : ld_issue

`default_nettype wire

//--- source/ld_return.sv
// Load return, m and r stages
// Merges store buffer forwarding bytes over the DCCM read words in m,
// registers the merge into r, then aligns the result to the load offset
// and masks it to the load size.
`timescale 1ns/100ps
`default_nettype none

module ld_return (
   input  logic                  clk,
   input  logic                  arst_n,
   input  lsu_pipe_pkg::ld_pkt_t ld_pkt_m,
   input  lsu_pipe_pkg::fwd_t    fwd,
   input  dccm_geom_pkg::word_t  dccm_rd_data_lo,
   input  dccm_geom_pkg::word_t  dccm_rd_data_hi,
   output lsu_pipe_pkg::ld_rsp_t ld_rsp
);

   localparam int unsigned DW = dccm_geom_pkg::DATA_WIDTH;
   localparam int unsigned WB = dccm_geom_pkg::WIDTH_BITS;
   localparam int unsigned NB = 2 * dccm_geom_pkg::BYTE_WIDTH;    // lo and hi byte lanes
   localparam int unsigned BW = DW / dccm_geom_pkg::BYTE_WIDTH;   // bits per byte lane

   logic [2*DW-1:0]        rd_m;                            // hi word over lo word
   logic [2*DW-1:0]        merge_m;

   // r stage registers
   logic                   valid_r;
   lsu_pipe_pkg::ld_size_e size_r;
   logic [WB-1:0]          offset_r;
   dccm_geom_pkg::word_t   merge_lo_r;
   dccm_geom_pkg::word_t   merge_hi_r;

   logic [2*DW-1:0]        shifted_r;
   dccm_geom_pkg::word_t   mask_r;

   assign rd_m = {dccm_rd_data_hi, dccm_rd_data_lo};

   // forwarded bytes win over the array data
   for (genvar i = 0; i < NB; i++) begin : g_merge
      assign merge_m[BW*i +: BW] = fwd.byteen[i] ? fwd.data[BW*i +: BW]
                                                  : rd_m[BW*i +: BW];
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         valid_r <= 1'b0;
      end else begin
         valid_r <= ld_pkt_m.valid;
      end
   end

   always_ff @(posedge clk) begin
      if (ld_pkt_m.valid) begin
         size_r     <= ld_pkt_m.size;
         offset_r   <= ld_pkt_m.offset;
         merge_lo_r <= merge_m[DW-1:0];
      end
   end

   // hi half only matters when the load spans two words
   always_ff @(posedge clk) begin
      if (ld_pkt_m.valid && ld_pkt_m.dual) begin
         merge_hi_r <= merge_m[2*DW-1:DW];
      end
   end

   // first load byte moves down to lane 0
   assign shifted_r = {merge_hi_r, merge_lo_r} >> (BW * offset_r);

   always_comb begin
      case (size_r)
         lsu_pipe_pkg::LD_BYTE: mask_r = DW'({BW{1'b1}});
         lsu_pipe_pkg::LD_HALF: mask_r = DW'({(2*BW){1'b1}});
         default:               mask_r = '1;
      endcase
   end

   assign ld_rsp = '{
      valid: valid_r,
      data:  shifted_r[DW-1:0] & mask_r                     // upper bytes zero extended
   };

endmodule : ld_return

`default_nettype wire

//--- source/lsu_pipe_pkg.sv
// LSU pipe traffic
// packets and port bundles that move between the d, m and r stages,
// the store buffer and the DCCM ports
`default_nettype none

package lsu_pipe_pkg;

   typedef enum logic [1:0] {
      LD_BYTE = 2'd0,
      LD_HALF = 2'd1,
      LD_WORD = 2'd2
   } ld_size_e;

   typedef struct packed {
      logic                                 valid;          // single cycle strobe
      ld_size_e                             size;
      dccm_geom_pkg::addr_t                 addr;
   } ld_req_t;

   typedef struct packed {
      logic                                 valid;
      ld_size_e                             size;
      logic [dccm_geom_pkg::WIDTH_BITS-1:0] offset;         // byte offset of the load
      logic                                 dual;           // crosses a word boundary
   } ld_pkt_t;

   typedef struct packed {
      logic [2*dccm_geom_pkg::BYTE_WIDTH-1:0] byteen;       // hi word bytes on top
      logic [2*dccm_geom_pkg::DATA_WIDTH-1:0] data;
   } fwd_t;

   typedef struct packed {
      logic                                 valid;          // held until commit
      dccm_geom_pkg::addr_t                 addr;           // word aligned
      dccm_geom_pkg::word_t                 data;
   } stbuf_req_t;

   typedef struct packed {
      logic                                 rden;
      dccm_geom_pkg::addr_t                 addr_lo;
      dccm_geom_pkg::addr_t                 addr_hi;
   } dccm_rd_t;

   typedef struct packed {
      logic                                 wren;
      dccm_geom_pkg::addr_t                 addr;
      dccm_geom_pkg::word_t                 data;
   } dccm_wr_t;

   typedef struct packed {
      logic                                 valid;
      dccm_geom_pkg::word_t                 data;           // right justified, zero extended
   } ld_rsp_t;

endpackage : lsu_pipe_pkg

`default_nettype wire

//--- source/stbuf_commit_arb.sv
// Store buffer commit arbiter
// Gives the single DCCM write port to the store buffer whenever the
// d stage load read does not use the bank of the store address, and
// drives the write port in the same cycle.
`timescale 1ns/100ps
`default_nettype none

module stbuf_commit_arb #(
   parameter int unsigned BANK_BITS = dccm_geom_pkg::DEFAULT_BANK_BITS
) (
   input  lsu_pipe_pkg::dccm_rd_t   dccm_rd,
   input  lsu_pipe_pkg::stbuf_req_t stbuf_req,
   output logic                     stbuf_commit,
   output lsu_pipe_pkg::dccm_wr_t   dccm_wr
);

   localparam int unsigned WB = dccm_geom_pkg::WIDTH_BITS;

   logic [BANK_BITS-1:0] st_bank;
   logic [BANK_BITS-1:0] lo_bank;
   logic [BANK_BITS-1:0] hi_bank;
   logic                 bank_hit;                          // store bank used by the load read

   // bank is the field just above the byte offset
   assign st_bank = stbuf_req.addr[WB +: BANK_BITS];
   assign lo_bank = dccm_rd.addr_lo[WB +: BANK_BITS];
   assign hi_bank = dccm_rd.addr_hi[WB +: BANK_BITS];

   assign bank_hit = (st_bank == lo_bank) | (st_bank == hi_bank);

   // a load read only blocks the store when it lands in the same bank
   assign stbuf_commit = stbuf_req.valid & (~dccm_rd.rden | ~bank_hit);

   // write port follows the commit strobe in the same cycle
   assign dccm_wr.wren = stbuf_commit;
   assign dccm_wr.addr = stbuf_req.addr;
   assign dccm_wr.data = stbuf_req.data;

endmodule : stbuf_commit_arb

`default_nettype wire

//--- tb/dccm_ctl_chk.sv
// DCCM controller port checker
// concurrent assertions on the top level ports, bound into the DUT
`timescale 1ns/100ps
`default_nettype none

module dccm_ctl_chk #(
   parameter int unsigned BANK_BITS = dccm_geom_pkg::DEFAULT_BANK_BITS
) (
   input logic                     clk,
   input logic                     arst_n,
   input lsu_pipe_pkg::ld_req_t    ld_req,
   input lsu_pipe_pkg::stbuf_req_t stbuf_req,
   input logic                     stbuf_commit,
   input lsu_pipe_pkg::dccm_rd_t   dccm_rd,
   input lsu_pipe_pkg::dccm_wr_t   dccm_wr,
   input lsu_pipe_pkg::ld_rsp_t    ld_rsp
);

   localparam int unsigned WB = dccm_geom_pkg::WIDTH_BITS;

   int unsigned fail_count = 0;                             // read by the testbench summary

   function automatic logic [BANK_BITS-1:0] bank_of(input dccm_geom_pkg::addr_t a);
      return a[WB +: BANK_BITS];
   endfunction

   a_commit_needs_req : assert property (@(posedge clk) disable iff (!arst_n)
      stbuf_commit |-> stbuf_req.valid)
      else begin
         $error("store buffer commit without a valid request");
         fail_count++;
      end

   a_wren_is_commit : assert property (@(posedge clk) disable iff (!arst_n)
      dccm_wr.wren == stbuf_commit)
      else begin
         $error("DCCM write enable differs from the commit strobe");
         fail_count++;
      end

   // fixed two cycle load latency
   a_rsp_latency : assert property (@(posedge clk) disable iff (!arst_n)
      ld_req.valid |-> ##2 ld_rsp.valid)
      else begin
         $error("load response missing two cycles after issue");
         fail_count++;
      end

   a_bank_conflict : assert property (@(posedge clk) disable iff (!arst_n)
      (dccm_rd.rden && stbuf_commit) |->
         (bank_of(stbuf_req.addr) != bank_of(dccm_rd.addr_lo)) &&
         (bank_of(stbuf_req.addr) != bank_of(dccm_rd.addr_hi)))
      else begin
         $error("store committed into a bank read by the d stage load");
         fail_count++;
      end

endmodule : dccm_ctl_chk

`default_nettype wire

//--- tb/dccm_ctl_scoreboard.sv
// DCCM controller scoreboard
// keeps a shadow of the DCCM, predicts each load response from the
// load data rule and compares responses in issue order
`timescale 1ns/100ps
`default_nettype none

module dccm_ctl_scoreboard (
   input  logic                   clk,
   input  logic                   arst_n,
   input  lsu_pipe_pkg::ld_req_t  ld_req,
   input  lsu_pipe_pkg::fwd_t     fwd,
   input  lsu_pipe_pkg::dccm_rd_t dccm_rd,
   input  lsu_pipe_pkg::dccm_wr_t dccm_wr,
   input  lsu_pipe_pkg::ld_rsp_t  ld_rsp,
   input  logic                   drain_check,              // end of test, queue must be empty
   output int unsigned            error_count,
   output int unsigned            match_count
);

   localparam int unsigned AB    = dccm_geom_pkg::DCCM_BITS;
   localparam int unsigned WB    = dccm_geom_pkg::WIDTH_BITS;
   localparam int unsigned WORDS = 2 ** (AB - WB);

   dccm_geom_pkg::word_t   shadow [WORDS];
   dccm_geom_pkg::word_t   exp_q [$];                       // predictions waiting for r
   dccm_geom_pkg::word_t   exp_word;
   lsu_pipe_pkg::dccm_rd_t exp_rd;

   // load held in m until its forwarding is seen
   logic                   m_valid;
   lsu_pipe_pkg::ld_req_t  m_req;
   dccm_geom_pkg::word_t   m_lo;
   dccm_geom_pkg::word_t   m_hi;

   // preload pattern of word w, also used by the memory model
   function automatic dccm_geom_pkg::word_t fill_word(input int unsigned w);
      logic [13:0] a;
      a = w[13:0];
      return dccm_geom_pkg::word_t'({a, 2'b01, ~a, 2'b10});
   endfunction

   function automatic int unsigned load_bytes(input lsu_pipe_pkg::ld_size_e s);
      case (s)
         lsu_pipe_pkg::LD_BYTE: return 1;
         lsu_pipe_pkg::LD_HALF: return 2;
         default:               return 4;
      endcase
   endfunction

   function automatic dccm_geom_pkg::addr_t word_base(input dccm_geom_pkg::addr_t a);
      return {a[AB-1:WB], {WB{1'b0}}};
   endfunction

   function automatic dccm_geom_pkg::addr_t last_addr(input lsu_pipe_pkg::ld_req_t r);
      return r.addr + dccm_geom_pkg::addr_t'(load_bytes(r.size) - 1);
   endfunction

   // reference model of the load data rule
   function automatic dccm_geom_pkg::word_t expected_data(
      input lsu_pipe_pkg::ld_req_t r,
      input dccm_geom_pkg::word_t  lo,
      input dccm_geom_pkg::word_t  hi,
      input lsu_pipe_pkg::fwd_t    f
   );
      logic [63:0]          rd;
      logic [7:0]           merged [8];
      dccm_geom_pkg::word_t result;
      int unsigned          off;
      rd = {hi, lo};
      for (int i = 0; i < 8; i++) begin
         merged[i] = f.byteen[i] ? f.data[8*i +: 8] : rd[8*i +: 8];
      end
      off    = r.addr[WB-1:0];
      result = '0;
      for (int k = 0; k < int'(load_bytes(r.size)); k++) begin
         result[8*k +: 8] = merged[off + k];
      end
      return result;
   endfunction

   initial begin
      error_count = 0;
      match_count = 0;
      m_valid     = 1'b0;
      for (int w = 0; w < WORDS; w++) begin
         shadow[w] = fill_word(w);
      end
   end

   always @(posedge clk) begin
      if (!arst_n) begin
         m_valid = 1'b0;
         exp_q.delete();
      end else begin
         if (ld_rsp.valid) begin
            if (exp_q.size() == 0) begin
               $display("%0t ns: load response arrived with no load outstanding", $time);
               error_count++;
            end else begin
               exp_word = exp_q.pop_front();
               if (ld_rsp.data !== exp_word) begin
                  $display("Error: %0t ns ld_rsp.data expected %h actual %h",
                           $time, exp_word, ld_rsp.data);
                  error_count++;
               end else begin
                  match_count++;
               end
            end
         end
         if (m_valid) exp_q.push_back(expected_data(m_req, m_lo, m_hi, fwd));  // fwd is in m now
         exp_rd.rden    = ld_req.valid;
         exp_rd.addr_lo = word_base(ld_req.addr);
         exp_rd.addr_hi = word_base(last_addr(ld_req));
         if (dccm_rd.rden !== exp_rd.rden || (ld_req.valid && dccm_rd !== exp_rd)) begin
            $display("Error: %0t ns dccm_rd expected %h actual %h", $time, exp_rd, dccm_rd);
            error_count++;
         end
         m_valid = ld_req.valid;
         if (ld_req.valid) begin
            m_req = ld_req;
            m_lo  = shadow[exp_rd.addr_lo[AB-1:WB]];        // read before the write below
            m_hi  = shadow[exp_rd.addr_hi[AB-1:WB]];
         end
         if (dccm_wr.wren) shadow[dccm_wr.addr[AB-1:WB]] = dccm_wr.data;
         if (drain_check && (exp_q.size() != 0 || m_valid)) begin
            $display("%0t ns: loads still outstanding at the end of the test", $time);
            error_count++;
         end
      end
   end

endmodule : dccm_ctl_scoreboard

`default_nettype wire

//--- tb/tb_dccm_ctl.sv
// DCCM controller testbench
// drives loads, forwarding and store buffer entries into the DUT,
// models the DCCM array and prints the closing summary
`timescale 1ns/100ps
`default_nettype none

module tb_dccm_ctl;

   localparam int unsigned BANK_BITS = dccm_geom_pkg::DEFAULT_BANK_BITS;
   localparam int unsigned AB        = dccm_geom_pkg::DCCM_BITS;
   localparam int unsigned WB        = dccm_geom_pkg::WIDTH_BITS;
   localparam int unsigned WORDS     = 2 ** (AB - WB);
   localparam int          TIMEOUT   = 64;

   logic                     clk;
   logic                     arst_n;
   lsu_pipe_pkg::ld_req_t    ld_req;
   lsu_pipe_pkg::stbuf_req_t stbuf_req;
   lsu_pipe_pkg::fwd_t       fwd;
   dccm_geom_pkg::word_t     dccm_rd_data_lo;
   dccm_geom_pkg::word_t     dccm_rd_data_hi;
   lsu_pipe_pkg::dccm_rd_t   dccm_rd;
   lsu_pipe_pkg::dccm_wr_t   dccm_wr;
   logic                     stbuf_commit;
   lsu_pipe_pkg::ld_rsp_t    ld_rsp;

   logic                     drain_check;
   int unsigned              sb_errors;
   int unsigned              sb_matches;
   int unsigned              tb_errors = 0;
   int unsigned              chk_fails;
   int                       seed = 32'h8496;
   lsu_pipe_pkg::fwd_t       pend_fwd;                      // fwd of the load now in d
   dccm_geom_pkg::word_t     mem [WORDS];

   dccm_ctl_top #(
      .BANK_BITS (BANK_BITS)
   ) i_dccm_ctl_top (
      .clk             (clk),
      .arst_n          (arst_n),
      .ld_req          (ld_req),
      .stbuf_req       (stbuf_req),
      .fwd             (fwd),
      .stbuf_commit    (stbuf_commit),
      .ld_rsp          (ld_rsp),
      .dccm_rd         (dccm_rd),
      .dccm_wr         (dccm_wr),
      .dccm_rd_data_lo (dccm_rd_data_lo),
      .dccm_rd_data_hi (dccm_rd_data_hi)
   );

   dccm_ctl_scoreboard i_dccm_ctl_scoreboard (
      .clk         (clk),
      .arst_n      (arst_n),
      .ld_req      (ld_req),
      .fwd         (fwd),
      .dccm_rd     (dccm_rd),
      .dccm_wr     (dccm_wr),
      .ld_rsp      (ld_rsp),
      .drain_check (drain_check),
      .error_count (sb_errors),
      .match_count (sb_matches)
   );

   bind dccm_ctl_top dccm_ctl_chk #(
      .BANK_BITS (BANK_BITS)
   ) i_dccm_ctl_chk (
      .clk          (clk),
      .arst_n       (arst_n),
      .ld_req       (ld_req),
      .stbuf_req    (stbuf_req),
      .stbuf_commit (stbuf_commit),
      .dccm_rd      (dccm_rd),
      .dccm_wr      (dccm_wr),
      .ld_rsp       (ld_rsp)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // DCCM model, read before write, one cycle read latency
   always @(posedge clk) begin
      if (dccm_rd.rden) begin
         dccm_rd_data_lo <= mem[dccm_rd.addr_lo[AB-1:WB]];
         dccm_rd_data_hi <= mem[dccm_rd.addr_hi[AB-1:WB]];
      end
      if (dccm_wr.wren) mem[dccm_wr.addr[AB-1:WB]] <= dccm_wr.data;
   end

   function automatic logic [BANK_BITS-1:0] bank_of(input dccm_geom_pkg::addr_t a);
      return a[WB +: BANK_BITS];
   endfunction

   // one cycle in d, the previous load moves to m with its forwarding
   task automatic load_cycle(input lsu_pipe_pkg::ld_req_t req, input lsu_pipe_pkg::fwd_t f);
      @(posedge clk);
      ld_req   <= req;
      fwd      <= pend_fwd;
      pend_fwd  = f;
   endtask

   task automatic drain_pipe();
      repeat (3) load_cycle('0, '0);                        // d, m and r empty again
   endtask

   task automatic random_load(input dccm_geom_pkg::addr_t base);
      int                    r;
      lsu_pipe_pkg::ld_req_t req;
      lsu_pipe_pkg::fwd_t    f;
      r         = $random(seed);
      req.valid = r[1:0] != 2'b00;
      req.size  = lsu_pipe_pkg::ld_size_e'(r[3:2] % 2'd3);
      req.addr  = base + dccm_geom_pkg::addr_t'(r[13:8]);  // 16 words over all banks
      f.byteen  = r[23:16] & r[31:24];
      f.data    = {$random(seed), $random(seed)};
      if (!req.valid) f = '0;
      load_cycle(req, f);
   endtask

   task automatic wait_response(output int cycles);
      cycles = 0;
      do begin
         load_cycle('0, '0);
         cycles++;
         @(negedge clk);
      end while (!ld_rsp.valid && cycles < TIMEOUT);
      if (!ld_rsp.valid) begin
         $display("%0t ns: no load response within %0d cycles", $time, TIMEOUT);
         tb_errors++;
      end
   endtask

   // holds one entry until it commits, checking the bank rule every cycle
   task automatic store_entry(input dccm_geom_pkg::addr_t addr, input dccm_geom_pkg::word_t data,
                              output int cycles);
      logic                   exp_commit;
      lsu_pipe_pkg::dccm_wr_t exp_wr;
      cycles = 0;
      exp_wr = '{wren: 1'b1, addr: addr, data: data};       // write port carries the held entry
      @(posedge clk);
      stbuf_req <= '{valid: 1'b1, addr: addr, data: data};
      do begin
         @(negedge clk);
         cycles++;
         exp_commit = !dccm_rd.rden ||
                      (bank_of(addr) != bank_of(dccm_rd.addr_lo) &&
                       bank_of(addr) != bank_of(dccm_rd.addr_hi));
         if (stbuf_commit !== exp_commit) begin
            $display("Error: %0t ns stbuf_commit expected %b actual %b",
                     $time, exp_commit, stbuf_commit);
            tb_errors++;
         end
         if (stbuf_commit === 1'b1 && dccm_wr !== exp_wr) begin
            $display("Error: %0t ns dccm_wr expected %h actual %h", $time, exp_wr, dccm_wr);
            tb_errors++;
         end
      end while (!stbuf_commit && cycles < TIMEOUT);
      if (!stbuf_commit) begin
         $display("%0t ns: store entry at %h never committed", $time, addr);
         tb_errors++;
      end
   endtask

   initial begin
      int cycles;
      int r;
      arst_n          = 1'b0;
      ld_req          = '0;
      stbuf_req       = '0;
      fwd             = '0;
      pend_fwd        = '0;
      dccm_rd_data_lo = '0;
      dccm_rd_data_hi = '0;
      drain_check     = 1'b0;
      for (int w = 0; w < WORDS; w++) begin
         mem[w] = i_dccm_ctl_scoreboard.fill_word(w);
      end
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;

      // quiet after reset, then one aligned word load
      repeat (4) begin
         @(negedge clk);
         if (ld_rsp.valid || stbuf_commit) begin
            $display("%0t ns: response or commit seen with no request present", $time);
            tb_errors++;
         end
      end
      load_cycle('{valid: 1'b1, size: lsu_pipe_pkg::LD_WORD, addr: 16'h0040}, '0);
      wait_response(cycles);
      if (cycles != 2) begin
         $display("%0t ns: aligned load answered after %0d cycles, not 2", $time, cycles);
         tb_errors++;
      end

      // every size at every offset, including the dual loads
      for (int s = 0; s < 3; s++) begin
         for (int o = 0; o < 4; o++) begin
            load_cycle('{valid: 1'b1, size: lsu_pipe_pkg::ld_size_e'(s),
                         addr: dccm_geom_pkg::addr_t'(16'h0100 + 8 * s + o)}, '0);
         end
      end
      drain_pipe();

      repeat (80) random_load(16'h0300);                    // random forwarding
      drain_pipe();

      // no load in d, so the store commits at once
      r = $random(seed);
      store_entry(16'h0104, r, cycles);
      if (cycles != 1) begin
         $display("%0t ns: idle store took %0d cycles to commit", $time, cycles);
         tb_errors++;
      end
      @(posedge clk);
      stbuf_req <= '0;
      load_cycle('{valid: 1'b1, size: lsu_pipe_pkg::LD_WORD, addr: 16'h0104}, '0);
      load_cycle('{valid: 1'b1, size: lsu_pipe_pkg::LD_WORD, addr: 16'h0103}, '0);
      drain_pipe();

      // held stores against back-to-back random loads
      fork
         repeat (200) random_load(16'h0200);
         begin
            repeat (24) begin
               r = $random(seed);
               store_entry(dccm_geom_pkg::addr_t'(16'h0200 + {r[5:2], 2'b00}),
                           $random(seed), cycles);
            end
            @(posedge clk);
            stbuf_req <= '0;
         end
      join
      drain_pipe();
      for (int w = 0; w < 16; w++) begin
         load_cycle('{valid: 1'b1, size: lsu_pipe_pkg::LD_WORD,
                      addr: dccm_geom_pkg::addr_t'(16'h0200 + 4 * w)}, '0);
      end
      drain_pipe();

      drain_check <= 1'b1;
      @(posedge clk);
      drain_check <= 1'b0;
      @(negedge clk);
      if (sb_matches == 0) begin
         $display("no load response was compared");
         tb_errors++;
      end
      chk_fails = i_dccm_ctl_top.i_dccm_ctl_chk.fail_count;
      $display("Summary: %0d matched, %0d scoreboard errors, %0d tb errors, %0d assert failures",
               sb_matches, sb_errors, tb_errors, chk_fails);
      if (sb_errors + tb_errors + chk_fails == 0) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule : tb_dccm_ctl

`default_nettype wire
